/* ads1292_ctrl.sv */
// assumes the engine raises busy the cycle after WREG; samples are taken only while streaming
`timescale 1ns/100ps

module ads1292_ctrl (
	input  logic                                i_CLK,
	input  logic                                i_RST,
	input  logic                                i_chip_set_req,
	input  logic                                i_run_req,
	input  logic [sensor_pkg::ADS_SAMPLE_W-1:0] i_ads_data,
	input  logic                                i_ads_data_ready,
	input  logic                                i_ads_busy,
	input  logic                                i_take,
	output sensor_pkg::ads_bus_req_t            o_ads_bus,
	output logic                                o_chip_done,
	output logic                                o_run_done,
	output logic                                o_pending,
	output logic [sensor_pkg::ADS_SAMPLE_W-1:0] o_sample
);

	localparam int unsigned     IDX_W    = $clog2(sensor_pkg::ADS_INIT_LEN);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(sensor_pkg::ADS_INIT_LEN - 1);

	typedef enum logic [2:0] {ST_IDLE, ST_WREG, ST_ISSUE, ST_WAIT, ST_STREAM} state_e;

	state_e           r_state;
	logic [IDX_W-1:0] r_idx;
	logic             w_capture;

	assign w_capture = (r_state == ST_STREAM) & i_run_req & i_ads_data_ready;

	always_ff @(posedge i_CLK) begin
		if (w_capture) o_sample <= i_ads_data;
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state     <= ST_IDLE;
			r_idx       <= '0;
			o_ads_bus   <= '0; // ctrl IDLE
			o_chip_done <= 1'b0;
			o_run_done  <= 1'b0;
			o_pending   <= 1'b0;
		end else begin
			o_ads_bus.ctrl <= sensor_pkg::ADS_IDLE; // codes are one cycle unless held below
			if (w_capture) o_pending <= 1'b1;
			else if (i_take) o_pending <= 1'b0;
			case (r_state)
				ST_IDLE: begin
					if (i_chip_set_req && !o_chip_done) begin
						r_idx   <= '0;
						r_state <= ST_WREG;
					end else if (i_run_req && !o_run_done) begin
						o_ads_bus.ctrl <= sensor_pkg::ADS_RDATAC;
						o_run_done     <= 1'b1;
						r_state        <= ST_STREAM;
					end
				end

				// ==========================================================
				// register table via WREG
				// ==========================================================
				ST_WREG: begin
					o_ads_bus.ctrl  <= sensor_pkg::ADS_WREG;
					o_ads_bus.addr  <= sensor_pkg::ADS_INIT_TABLE[r_idx].addr;
					o_ads_bus.wdata <= sensor_pkg::ADS_INIT_TABLE[r_idx].data;
					r_state         <= ST_ISSUE;
				end
				ST_ISSUE: begin
					o_ads_bus.ctrl <= sensor_pkg::ADS_DUMMY;
					r_state        <= ST_WAIT;
				end
				ST_WAIT: begin
					if (i_ads_busy) begin
						o_ads_bus.ctrl <= sensor_pkg::ADS_DUMMY;
					end else if (r_idx == IDX_LAST) begin
						o_chip_done <= 1'b1;
						r_state     <= ST_IDLE;
					end else begin
						r_idx   <= r_idx + 1'b1;
						r_state <= ST_WREG;
					end
				end

				// continuous read until run_req drops
				ST_STREAM: begin
					if (!i_run_req) begin
						o_ads_bus.ctrl <= sensor_pkg::ADS_SDATAC;
						o_run_done     <= 1'b0;
						r_state        <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* host_link.sv */
// only the upper command byte is decoded; frames go out only while the UART reports ready
`timescale 1ns/100ps

module host_link (
	input  logic                                i_CLK,
	input  logic                                i_RST,
	input  logic [15:0]                         i_uart_rx,
	input  logic                                i_uart_rx_valid,
	input  logic                                i_uart_tx_ready,
	input  logic                                i_ads_pending,
	input  logic [sensor_pkg::ADS_SAMPLE_W-1:0] i_ads_sample,
	input  logic                                i_mpr_pending,
	input  logic [sensor_pkg::TOUCH_W-1:0]      i_touch,
	output logic                                o_run_mode,
	output logic                                o_ads_take,
	output logic                                o_mpr_take,
	output sensor_pkg::uart_frame_t             o_uart_tx,
	output logic                                o_uart_tx_valid
);

	logic [7:0] r_cmd;
	logic       r_cmd_valid;
	logic       w_send_ok;

	// ==========================================================
	// command decode
	// ==========================================================
	always_ff @(posedge i_CLK) begin
		if (i_uart_rx_valid) r_cmd <= i_uart_rx[15:8];
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_cmd_valid <= 1'b0;
			o_run_mode  <= 1'b0;
		end else begin
			r_cmd_valid <= i_uart_rx_valid;
			if (r_cmd_valid) begin
				if (r_cmd == sensor_pkg::CMD_RUN) o_run_mode <= 1'b1;
				else if (r_cmd == sensor_pkg::CMD_STOP) o_run_mode <= 1'b0;
			end
		end
	end

	// ==========================================================
	// frame arbitration, ADS first
	// ==========================================================
	// no new frame in the valid cycle, keeps valid a single pulse
	assign w_send_ok  = i_uart_tx_ready & ~o_uart_tx_valid;
	assign o_ads_take = w_send_ok & i_ads_pending;
	assign o_mpr_take = w_send_ok & i_mpr_pending & ~i_ads_pending;

	always_ff @(posedge i_CLK) begin
		if (o_ads_take) begin
			o_uart_tx.tag     <= sensor_pkg::TAG_ADS;
			o_uart_tx.payload <= i_ads_sample;
		end else if (o_mpr_take) begin
			o_uart_tx.tag     <= sensor_pkg::TAG_MPR;
			o_uart_tx.payload <= {4'b0, i_touch, 56'b0}; // status1[3:0], status0
		end
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) o_uart_tx_valid <= 1'b0;
		else o_uart_tx_valid <= o_ads_take | o_mpr_take;
	end

endmodule

/* mpr121_ctrl.sv */
// assumes the bus engine raises busy the cycle after enable; after a fail the job restarts from idle
`timescale 1ns/100ps

module mpr121_ctrl #(
	parameter int unsigned POLL_GAP = 1 // idle cycles between status pairs, at least one
) (
	input  logic                           i_CLK,
	input  logic                           i_RST,
	input  logic                           i_chip_set_req,
	input  logic                           i_run_req,
	input  logic [7:0]                     i_mpr_data,
	input  logic                           i_mpr_busy,
	input  logic                           i_mpr_fail,
	input  logic                           i_take,
	output sensor_pkg::mpr_bus_req_t       o_mpr_bus,
	output logic                           o_chip_done,
	output logic                           o_run_done,
	output logic                           o_pending,
	output logic [sensor_pkg::TOUCH_W-1:0] o_touch_status,
	output logic                           o_error
);

	localparam int unsigned     IDX_W    = $clog2(sensor_pkg::MPR_INIT_LEN);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(sensor_pkg::MPR_INIT_LEN - 1);
	localparam int unsigned     GAP_W    = $clog2(POLL_GAP + 2);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(POLL_GAP);

	typedef enum logic [2:0] {ST_IDLE, ST_SETUP, ST_EN, ST_ISSUE, ST_WAIT, ST_GAP} state_e;
	typedef enum logic [2:0] {JOB_INIT, JOB_RUN, JOB_STOP, JOB_POLL0, JOB_POLL1} job_e;

	state_e                   r_state;
	job_e                     r_job;   // what the current transfer belongs to
	sensor_pkg::mpr_bus_req_t r_req;   // next transfer, enables included
	logic [IDX_W-1:0]         r_idx;
	logic [GAP_W-1:0]         r_gap;
	logic [7:0]               r_stat0;

	function automatic sensor_pkg::mpr_bus_req_t mk_req(
		input logic [7:0] addr,
		input logic [7:0] data,
		input logic       rd
	);
		return '{addr: addr, wdata: data, wr_en: ~rd, rd_en: rd};
	endfunction

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state        <= ST_IDLE;
			r_job          <= JOB_INIT;
			r_req          <= '0;
			r_idx          <= '0;
			r_gap          <= '0;
			r_stat0        <= '0;
			o_mpr_bus      <= '0;
			o_chip_done    <= 1'b0;
			o_run_done     <= 1'b0;
			o_pending      <= 1'b0;
			o_touch_status <= '0;
			o_error        <= 1'b0;
		end else begin
			if (i_take) o_pending <= 1'b0; // a new pair below wins
			case (r_state)
				// ==========================================================
				// job dispatch
				// ==========================================================
				ST_IDLE: begin
					if (i_chip_set_req && !o_chip_done) begin
						r_idx   <= '0;
						r_req   <= mk_req(sensor_pkg::MPR_INIT_TABLE[0].addr,
							sensor_pkg::MPR_INIT_TABLE[0].data, 1'b0);
						r_job   <= JOB_INIT;
						r_state <= ST_SETUP;
					end else if (i_run_req && !o_run_done) begin
						r_req   <= mk_req(sensor_pkg::MPR_ELE_CONFIG_REG, sensor_pkg::MPR_ELE_RUN, 1'b0);
						r_job   <= JOB_RUN;
						r_state <= ST_SETUP;
					end else if (!i_run_req && o_run_done) begin
						r_req   <= mk_req(sensor_pkg::MPR_ELE_CONFIG_REG, sensor_pkg::MPR_ELE_STOP, 1'b0);
						r_job   <= JOB_STOP;
						r_state <= ST_SETUP;
					end else if (i_run_req && o_run_done) begin // resume after a failed poll
						r_req   <= mk_req(sensor_pkg::MPR_STATUS0_REG, 8'h00, 1'b1);
						r_job   <= JOB_POLL0;
						r_state <= ST_SETUP;
					end
				end

				// ==========================================================
				// shared transfer sub-sequence
				// ==========================================================
				ST_SETUP: begin
					o_mpr_bus.addr  <= r_req.addr;  // settle one cycle ahead of enable
					o_mpr_bus.wdata <= r_req.wdata;
					r_state         <= ST_EN;
				end
				ST_EN: begin
					o_mpr_bus <= r_req;
					r_state   <= ST_ISSUE;
				end
				ST_ISSUE: begin
					o_mpr_bus.wr_en <= 1'b0;
					o_mpr_bus.rd_en <= 1'b0;
					r_state         <= ST_WAIT; // engine busy shows up from here
				end
				ST_WAIT: begin
					if (!i_mpr_busy) begin
						if (i_mpr_fail) begin
							o_error <= 1'b1; // sticky until reset
							r_state <= ST_IDLE;
						end else begin
							case (r_job)
								JOB_INIT: begin
									if (r_idx == IDX_LAST) begin
										o_chip_done <= 1'b1;
										r_state     <= ST_IDLE;
									end else begin
										r_idx   <= r_idx + 1'b1;
										r_req   <= mk_req(sensor_pkg::MPR_INIT_TABLE[r_idx + 1'b1].addr,
											sensor_pkg::MPR_INIT_TABLE[r_idx + 1'b1].data, 1'b0);
										r_state <= ST_SETUP;
									end
								end
								JOB_RUN: begin
									o_run_done <= 1'b1;
									r_req      <= mk_req(sensor_pkg::MPR_STATUS0_REG, 8'h00, 1'b1);
									r_job      <= JOB_POLL0;
									r_state    <= ST_SETUP;
								end
								JOB_POLL0: begin
									r_stat0 <= i_mpr_data;
									r_req   <= mk_req(sensor_pkg::MPR_STATUS1_REG, 8'h00, 1'b1);
									r_job   <= JOB_POLL1;
									r_state <= ST_SETUP;
								end
								JOB_POLL1: begin
									o_touch_status <= {i_mpr_data[3:0], r_stat0};
									o_pending      <= 1'b1;
									r_gap          <= GAP_W'(1);
									r_state        <= ST_GAP;
								end
								default: begin // stop write done
									o_run_done <= 1'b0;
									r_state    <= ST_IDLE;
								end
							endcase
						end
					end
				end

				ST_GAP: begin
					if (r_gap >= GAP_LAST) begin
						r_state <= ST_SETUP;
						if (!i_run_req) begin
							r_req <= mk_req(sensor_pkg::MPR_ELE_CONFIG_REG, sensor_pkg::MPR_ELE_STOP, 1'b0);
							r_job <= JOB_STOP;
						end else begin
							r_req <= mk_req(sensor_pkg::MPR_STATUS0_REG, 8'h00, 1'b1);
							r_job <= JOB_POLL0;
						end
					end else begin
						r_gap <= r_gap + 1'b1;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the sensor_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sensor_core -f sensor_core.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^All checks passed$"; then
	exit 0
fi
exit 1

/* sensor_core.f */
sensor_pkg.sv
host_link.sv
sensor_sequencer.sv
mpr121_ctrl.sv
ads1292_ctrl.sv
sensor_core.sv
sensor_core_chk.sv
tb_sensor_core.sv

/* sensor_core.sv */
// top level; both bus engines sit outside and the UART transmitter must accept any frame sent while ready
`timescale 1ns/100ps

module sensor_core #(
	parameter int unsigned POLL_GAP = 1
) (
	input  logic                                i_CLK,
	input  logic                                i_RST,
	input  logic [15:0]                         i_uart_rx,
	input  logic                                i_uart_rx_valid,
	input  logic                                i_uart_tx_ready,
	input  logic [7:0]                          i_mpr_data,
	input  logic                                i_mpr_init_set,
	input  logic                                i_mpr_busy,
	input  logic                                i_mpr_fail,
	input  logic [sensor_pkg::ADS_SAMPLE_W-1:0] i_ads_data,
	input  logic                                i_ads_init_set,
	input  logic                                i_ads_data_ready,
	input  logic                                i_ads_busy,
	output sensor_pkg::uart_frame_t             o_uart_tx,
	output logic                                o_uart_tx_valid,
	output sensor_pkg::mpr_bus_req_t            o_mpr_bus,
	output logic [sensor_pkg::TOUCH_W-1:0]      o_touch_status,
	output logic                                o_mpr_error,
	output sensor_pkg::ads_bus_req_t            o_ads_bus,
	output logic                                o_chip_set,
	output logic                                o_run_set
);

	logic                                w_run_mode;
	logic                                w_chip_set_req;
	logic                                w_run_req;
	logic                                w_mpr_chip_done, w_ads_chip_done;
	logic                                w_mpr_run_done, w_ads_run_done;
	logic                                w_mpr_pending, w_mpr_take;
	logic                                w_ads_pending, w_ads_take;
	logic [sensor_pkg::ADS_SAMPLE_W-1:0] w_ads_sample;

	host_link host_link_i (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_uart_rx(i_uart_rx), .i_uart_rx_valid(i_uart_rx_valid),
		.i_uart_tx_ready(i_uart_tx_ready),
		.i_ads_pending(w_ads_pending), .i_ads_sample(w_ads_sample),
		.i_mpr_pending(w_mpr_pending), .i_touch(o_touch_status),
		.o_run_mode(w_run_mode),
		.o_ads_take(w_ads_take), .o_mpr_take(w_mpr_take),
		.o_uart_tx(o_uart_tx), .o_uart_tx_valid(o_uart_tx_valid)
	);

	sensor_sequencer sensor_sequencer_i (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_mpr_init_set(i_mpr_init_set), .i_ads_init_set(i_ads_init_set),
		.i_run_mode(w_run_mode),
		.i_mpr_chip_done(w_mpr_chip_done), .i_ads_chip_done(w_ads_chip_done),
		.i_mpr_run_done(w_mpr_run_done), .i_ads_run_done(w_ads_run_done),
		.o_chip_set_req(w_chip_set_req), .o_run_req(w_run_req),
		.o_chip_set(o_chip_set), .o_run_set(o_run_set)
	);

	mpr121_ctrl #(.POLL_GAP(POLL_GAP)) mpr121_ctrl_i (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_chip_set_req(w_chip_set_req), .i_run_req(w_run_req),
		.i_mpr_data(i_mpr_data), .i_mpr_busy(i_mpr_busy), .i_mpr_fail(i_mpr_fail),
		.i_take(w_mpr_take),
		.o_mpr_bus(o_mpr_bus),
		.o_chip_done(w_mpr_chip_done), .o_run_done(w_mpr_run_done),
		.o_pending(w_mpr_pending), .o_touch_status(o_touch_status),
		.o_error(o_mpr_error)
	);

	ads1292_ctrl ads1292_ctrl_i (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_chip_set_req(w_chip_set_req), .i_run_req(w_run_req),
		.i_ads_data(i_ads_data), .i_ads_data_ready(i_ads_data_ready),
		.i_ads_busy(i_ads_busy), .i_take(w_ads_take),
		.o_ads_bus(o_ads_bus),
		.o_chip_done(w_ads_chip_done), .o_run_done(w_ads_run_done),
		.o_pending(w_ads_pending), .o_sample(w_ads_sample)
	);

endmodule

/* sensor_core_chk.sv */
// bound to sensor_core; checks the UART and bus handshakes outside of reset only
`timescale 1ns/100ps

module sensor_core_chk (
	input logic                     i_CLK,
	input logic                     i_RST,
	input logic                     i_uart_tx_ready,
	input logic                     i_uart_tx_valid,
	input sensor_pkg::mpr_bus_req_t i_mpr_bus,
	input sensor_pkg::ads_bus_req_t i_ads_bus
);

	// ==========================================================
	// handshake properties
	// ==========================================================
	// frame launched only from a ready cycle
	a_valid_ready: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_uart_tx_valid |-> $past(i_uart_tx_ready))
		else $error("uart valid without ready");

	a_wr_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_mpr_bus.wr_en |=> !i_mpr_bus.wr_en)
		else $error("MPR write enable longer than one cycle");

	a_rd_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_mpr_bus.rd_en |=> !i_mpr_bus.rd_en)
		else $error("MPR read enable longer than one cycle");

	a_rd_wr_excl: assert property (@(posedge i_CLK) disable iff (i_RST)
		!(i_mpr_bus.wr_en && i_mpr_bus.rd_en))
		else $error("MPR read and write enable together");

	a_rdatac_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		(i_ads_bus.ctrl == sensor_pkg::ADS_RDATAC) |=> (i_ads_bus.ctrl != sensor_pkg::ADS_RDATAC))
		else $error("RDATAC longer than one cycle");

endmodule

bind sensor_core sensor_core_chk sensor_core_chk_i (
	.i_CLK(i_CLK), .i_RST(i_RST),
	.i_uart_tx_ready(i_uart_tx_ready), .i_uart_tx_valid(o_uart_tx_valid),
	.i_mpr_bus(o_mpr_bus), .i_ads_bus(o_ads_bus)
);

/* sensor_pkg.sv */
// shared types and constants; table data follows the MPR121 and ADS1292 datasheet recommendations
package sensor_pkg;

	// ==========================================================
	// host protocol
	// ==========================================================
	localparam logic [7:0] CMD_RUN  = 8'h52; // 'R'
	localparam logic [7:0] CMD_STOP = 8'h53; // 'S'
	localparam logic [7:0] TAG_MPR  = 8'hBB;
	localparam logic [7:0] TAG_ADS  = 8'hAA;

	localparam int unsigned TOUCH_W      = 12;
	localparam int unsigned ADS_SAMPLE_W = 72;

	typedef struct packed {
		logic [7:0]              tag;
		logic [ADS_SAMPLE_W-1:0] payload;
	} uart_frame_t;

	// ==========================================================
	// bus engine requests
	// ==========================================================
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic       wr_en; // one-cycle pulse
		logic       rd_en; // one-cycle pulse
	} mpr_bus_req_t;

	typedef enum logic [2:0] {
		ADS_IDLE   = 3'b000,
		ADS_SYSCMD = 3'b001,
		ADS_WREG   = 3'b010,
		ADS_RREG   = 3'b011,
		ADS_RDATAC = 3'b100,
		ADS_SDATAC = 3'b101,
		ADS_DUMMY  = 3'b111
	} ads_ctrl_e;

	typedef struct packed {
		ads_ctrl_e  ctrl;
		logic [7:0] addr;
		logic [7:0] wdata;
	} ads_bus_req_t;

	// ==========================================================
	// register tables
	// ==========================================================
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} reg_pair_t;

	localparam int unsigned MPR_INIT_LEN = 14;
	localparam reg_pair_t MPR_INIT_TABLE [MPR_INIT_LEN] = '{
		'{8'h2B, 8'h01}, '{8'h2C, 8'h01}, '{8'h2D, 8'h0E}, '{8'h2E, 8'h00}, // rising
		'{8'h2F, 8'h01}, '{8'h30, 8'h05}, '{8'h31, 8'h01}, '{8'h32, 8'h00}, // falling
		'{8'h33, 8'h00}, '{8'h34, 8'h00}, '{8'h35, 8'h00},                  // touched
		'{8'h5B, 8'h00}, '{8'h5C, 8'h10}, '{8'h5D, 8'h20}                   // debounce, filter
	};

	localparam logic [7:0] MPR_ELE_CONFIG_REG = 8'h5E;
	localparam logic [7:0] MPR_ELE_RUN        = 8'h8F; // all 12 electrodes
	localparam logic [7:0] MPR_ELE_STOP       = 8'h00;
	localparam logic [7:0] MPR_STATUS0_REG    = 8'h00; // ele 0..7
	localparam logic [7:0] MPR_STATUS1_REG    = 8'h01; // ele 8..11 in low nibble

	// RESP1/RESP2/CONFIG1 first, each of these resets the digital filter
	localparam int unsigned ADS_INIT_LEN = 11;
	localparam reg_pair_t ADS_INIT_TABLE [ADS_INIT_LEN] = '{
		'{8'h09, 8'h02}, '{8'h0A, 8'h03}, '{8'h01, 8'h01}, '{8'h02, 8'hE0},
		'{8'h03, 8'h10}, '{8'h04, 8'h00}, '{8'h05, 8'h00}, '{8'h06, 8'h2C},
		'{8'h07, 8'h0E}, '{8'h08, 8'h0F}, '{8'h0B, 8'h00}
	};

endpackage

/* sensor_sequencer.sv */
// chip setting starts only after both init_set inputs are high; run requests follow a four-phase handshake
`timescale 1ns/100ps

module sensor_sequencer (
	input  logic i_CLK,
	input  logic i_RST,
	input  logic i_mpr_init_set,
	input  logic i_ads_init_set,
	input  logic i_run_mode,
	input  logic i_mpr_chip_done,
	input  logic i_ads_chip_done,
	input  logic i_mpr_run_done,
	input  logic i_ads_run_done,
	output logic o_chip_set_req,
	output logic o_run_req,
	output logic o_chip_set,
	output logic o_run_set
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT_INIT,
		ST_CHIP_SET,
		ST_STANDBY,
		ST_STREAMING
	} state_e;

	state_e r_state;
	logic   w_all_run;
	logic   w_any_run;

	assign w_all_run = i_mpr_run_done & i_ads_run_done;
	assign w_any_run = i_mpr_run_done | i_ads_run_done;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state        <= ST_IDLE;
			o_chip_set_req <= 1'b0;
			o_run_req      <= 1'b0;
			o_chip_set     <= 1'b0;
			o_run_set      <= 1'b0;
		end else begin
			o_chip_set <= i_mpr_chip_done & i_ads_chip_done;
			o_run_set  <= w_all_run;
			case (r_state)
				ST_IDLE: r_state <= ST_WAIT_INIT;
				ST_WAIT_INIT: begin
					if (i_mpr_init_set & i_ads_init_set) begin
						o_chip_set_req <= 1'b1;
						r_state        <= ST_CHIP_SET;
					end
				end
				ST_CHIP_SET: begin
					if (i_mpr_chip_done & i_ads_chip_done) begin
						o_chip_set_req <= 1'b0; // tables are written once per reset
						r_state        <= ST_STANDBY;
					end
				end
				ST_STANDBY: begin
					// raise only once both chips have fully stopped
					if (i_run_mode & ~w_any_run) begin
						o_run_req <= 1'b1;
						r_state   <= ST_STREAMING;
					end
				end
				ST_STREAMING: begin
					if (~i_run_mode & w_all_run) begin
						o_run_req <= 1'b0;
						r_state   <= ST_STANDBY;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* tb_sensor_core.sv */
// UART ready held high, POLL_GAP left at its default; bus engines are fixed-latency models with random data
`timescale 1ns/100ps

module tb_sensor_core;

	localparam int CLK_HALF   = 20;   // 40 ns period
	localparam int MAX_CYCLES = 3000; // tests need about 800 cycles

	logic                                i_CLK;
	logic                                i_RST;
	logic [15:0]                         i_uart_rx;
	logic                                i_uart_rx_valid;
	logic                                i_uart_tx_ready;
	logic [7:0]                          i_mpr_data;
	logic                                i_mpr_init_set;
	logic                                i_mpr_busy;
	logic                                i_mpr_fail;
	logic [sensor_pkg::ADS_SAMPLE_W-1:0] i_ads_data;
	logic                                i_ads_init_set;
	logic                                i_ads_data_ready;
	logic                                i_ads_busy;
	sensor_pkg::uart_frame_t             o_uart_tx;
	logic                                o_uart_tx_valid;
	sensor_pkg::mpr_bus_req_t            o_mpr_bus;
	logic [sensor_pkg::TOUCH_W-1:0]      o_touch_status;
	logic                                o_mpr_error;
	sensor_pkg::ads_bus_req_t            o_ads_bus;
	logic                                o_chip_set;
	logic                                o_run_set;

	integer seed = 32'h7d460492;
	int     cycle_cnt = 0;

	// ==========================================================
	// model state
	// ==========================================================
	int          mpr_busy_cnt = 0;
	logic [7:0]  mpr_op_addr = '0;
	logic        mpr_op_rd = 1'b0;
	logic        mpr_op_fail = 1'b0;
	logic        mpr_fail_armed = 1'b0; // fail the next write
	logic [7:0]  last_s0 = '0;
	logic [7:0]  last_s1 = '0;
	int          mpr_pairs = 0;  // status pairs returned
	int          mpr_sent = 0;   // pair count at last MPR frame
	int          ads_busy_cnt = 0;
	int          ads_stream_cnt = 0;
	logic        ads_streaming = 1'b0;
	logic [71:0] last_ads = '0;
	int          ads_samples = 0;
	int          ads_sent = 0;
	logic        seen_rdatac = 1'b0;
	logic        seen_sdatac = 1'b0;
	int          frame_cnt = 0;

	sensor_pkg::mpr_bus_req_t mpr_wr_q[$]; // every MPR write, in order
	sensor_pkg::ads_bus_req_t ads_wr_q[$]; // every ADS WREG, in order

	sensor_core sensor_core_i (.*);

	initial begin
		i_CLK = 1'b0;
		forever #CLK_HALF i_CLK = ~i_CLK;
	end

	always @(posedge i_CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			stop_run($sformatf("timeout: the tests did not finish within %0d cycles", MAX_CYCLES));
	end

	// ==========================================================
	// reporting, reference and compare tasks
	// ==========================================================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic sensor_pkg::uart_frame_t expect_frame(input logic is_mpr,
		input logic [7:0] s0, input logic [7:0] s1, input logic [71:0] sample);
		sensor_pkg::uart_frame_t f;
		if (is_mpr) begin
			f.tag     = 8'hBB;
			f.payload = {4'b0000, s1[3:0], s0, 56'd0};
		end else begin
			f.tag     = 8'hAA;
			f.payload = sample;
		end
		return f;
	endfunction

	function automatic sensor_pkg::mpr_bus_req_t mpr_write_req(input logic [7:0] a,
		input logic [7:0] d);
		sensor_pkg::mpr_bus_req_t r;
		r.addr  = a;
		r.wdata = d;
		r.wr_en = 1'b1;
		r.rd_en = 1'b0;
		return r;
	endfunction

	function automatic sensor_pkg::ads_bus_req_t ads_wreg_req(input logic [7:0] a,
		input logic [7:0] d);
		sensor_pkg::ads_bus_req_t r;
		r.ctrl  = sensor_pkg::ADS_WREG;
		r.addr  = a;
		r.wdata = d;
		return r;
	endfunction

	task automatic check_frame(input sensor_pkg::uart_frame_t got,
		input sensor_pkg::uart_frame_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %h/%h expected %h/%h", $time, what,
				got.tag, got.payload, exp.tag, exp.payload));
	endtask

	task automatic check_mpr_req(input sensor_pkg::mpr_bus_req_t got,
		input sensor_pkg::mpr_bus_req_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_ads_req(input sensor_pkg::ads_bus_req_t got,
		input sensor_pkg::ads_bus_req_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_touch(input logic [sensor_pkg::TOUCH_W-1:0] got,
		input logic [sensor_pkg::TOUCH_W-1:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	// ==========================================================
	// bus engine models, updated 2 ns after each edge
	// ==========================================================
	task automatic finish_mpr_op();
		logic [7:0] b;
		b          = 8'($random(seed));
		i_mpr_busy = 1'b0;
		i_mpr_fail = mpr_op_fail;
		if (mpr_op_rd) begin
			i_mpr_data = b;
			if (mpr_op_addr == 8'h00) last_s0 = b;
			else begin
				last_s1   = b;
				mpr_pairs = mpr_pairs + 1;
			end
		end
	endtask

	initial begin : mpr_model
		i_mpr_busy = 1'b0;
		i_mpr_fail = 1'b0;
		i_mpr_data = '0;
		forever begin
			@(posedge i_CLK);
			#2;
			if (o_mpr_bus.wr_en || o_mpr_bus.rd_en) begin
				mpr_op_addr = o_mpr_bus.addr;
				mpr_op_rd   = o_mpr_bus.rd_en;
				mpr_op_fail = o_mpr_bus.wr_en & mpr_fail_armed;
				if (o_mpr_bus.wr_en) begin
					mpr_wr_q.push_back(o_mpr_bus);
					mpr_fail_armed = 1'b0;
				end
				i_mpr_fail   = 1'b0;
				i_mpr_busy   = 1'b1;
				mpr_busy_cnt = 3;
			end else if (mpr_busy_cnt > 0) begin
				mpr_busy_cnt = mpr_busy_cnt - 1;
				if (mpr_busy_cnt == 0) finish_mpr_op();
			end
		end
	end

	initial begin : ads_model
		i_ads_busy       = 1'b0;
		i_ads_data_ready = 1'b0;
		i_ads_data       = '0;
		forever begin
			@(posedge i_CLK);
			#2;
			i_ads_data_ready = 1'b0;
			if (o_ads_bus.ctrl == sensor_pkg::ADS_WREG) begin
				ads_wr_q.push_back(o_ads_bus);
				i_ads_busy   = 1'b1;
				ads_busy_cnt = 2;
			end else if (ads_busy_cnt > 0) begin
				ads_busy_cnt = ads_busy_cnt - 1;
				if (ads_busy_cnt == 0) i_ads_busy = 1'b0;
			end
			if (o_ads_bus.ctrl == sensor_pkg::ADS_RDATAC) begin
				ads_streaming  = 1'b1;
				ads_stream_cnt = 0;
				seen_rdatac    = 1'b1;
			end else if (o_ads_bus.ctrl == sensor_pkg::ADS_SDATAC) begin
				ads_streaming = 1'b0;
				seen_sdatac   = 1'b1;
			end else if (ads_streaming) begin
				ads_stream_cnt = ads_stream_cnt + 1;
				if (ads_stream_cnt == 20) begin // one sample every 20 cycles
					ads_stream_cnt   = 0;
					last_ads         = {8'($random(seed)), 32'($random(seed)), 32'($random(seed))};
					i_ads_data       = last_ads;
					i_ads_data_ready = 1'b1;
					ads_samples      = ads_samples + 1;
				end
			end
		end
	end

	// frames compared 1 ns after the edge, outputs settled by then
	initial begin : compare_frames
		sensor_pkg::uart_frame_t exp;
		forever begin
			@(posedge i_CLK);
			#1;
			if (!i_RST && o_uart_tx_valid) begin
				frame_cnt = frame_cnt + 1;
				if (o_uart_tx.tag == 8'hAA) begin
					if (ads_samples <= ads_sent) stop_run("an ADS frame was sent without a new sample");
					ads_sent = ads_samples;
					exp      = expect_frame(1'b0, 8'h00, 8'h00, last_ads);
				end else begin
					if (mpr_pairs <= mpr_sent) stop_run("an MPR frame was sent without a new status pair");
					mpr_sent = mpr_pairs;
					exp      = expect_frame(1'b1, last_s0, last_s1, '0);
					check_touch(o_touch_status, {last_s1[3:0], last_s0}, "touch status");
				end
				check_frame(o_uart_tx, exp, "host frame");
			end
		end
	end

	// ==========================================================
	// stimulus
	// ==========================================================
	task automatic step();
		@(posedge i_CLK);
		#2;
	endtask

	task automatic send_cmd(input logic [7:0] cmd);
		step();
		i_uart_rx       = {cmd, 8'h00};
		i_uart_rx_valid = 1'b1;
		step();
		i_uart_rx_valid = 1'b0;
	endtask

	initial begin : main_seq
		int i;
		int frames_before;
		i_RST           = 1'b1;
		i_uart_rx       = '0;
		i_uart_rx_valid = 1'b0;
		i_uart_tx_ready = 1'b1;
		i_mpr_init_set  = 1'b0;
		i_ads_init_set  = 1'b0;
		repeat (4) @(posedge i_CLK);
		#2 i_RST = 1'b0;

		// test 1, register tables
		step();
		i_mpr_init_set = 1'b1;
		i_ads_init_set = 1'b1;
		while (!o_chip_set) step();
		check_flag(mpr_wr_q.size() == sensor_pkg::MPR_INIT_LEN, 1'b1, "MPR table write count");
		for (i = 0; i < sensor_pkg::MPR_INIT_LEN; i++)
			check_mpr_req(mpr_wr_q[i], mpr_write_req(sensor_pkg::MPR_INIT_TABLE[i].addr,
				sensor_pkg::MPR_INIT_TABLE[i].data), "MPR table write");
		check_flag(ads_wr_q.size() == sensor_pkg::ADS_INIT_LEN, 1'b1, "ADS WREG count");
		for (i = 0; i < sensor_pkg::ADS_INIT_LEN; i++)
			check_ads_req(ads_wr_q[i], ads_wreg_req(sensor_pkg::ADS_INIT_TABLE[i].addr,
				sensor_pkg::ADS_INIT_TABLE[i].data), "ADS WREG");

		// test 2, run
		mpr_wr_q.delete();
		send_cmd(8'h52);
		while (!o_run_set) step();
		check_flag(mpr_wr_q.size() >= 1, 1'b1, "electrode enable written");
		check_mpr_req(mpr_wr_q[0], mpr_write_req(8'h5E, 8'h8F), "electrode enable");
		check_flag(seen_rdatac, 1'b1, "RDATAC issued");

		// tests 3 and 4, frames checked by the compare process
		repeat (400) step();
		check_flag(mpr_sent >= 3, 1'b1, "MPR frames seen");
		check_flag(ads_sent >= 3, 1'b1, "ADS frames seen");

		// test 5, stop
		mpr_wr_q.delete();
		send_cmd(8'h53);
		while (o_run_set) step();
		while (mpr_wr_q.size() == 0) step();
		check_mpr_req(mpr_wr_q[0], mpr_write_req(8'h5E, 8'h00), "electrode disable");
		check_flag(seen_sdatac, 1'b1, "SDATAC issued");
		repeat (20) step();
		frames_before = frame_cnt;
		repeat (150) step();
		check_flag(frame_cnt == frames_before, 1'b1, "no frames after stop");

		// test 6, forced write fail on restart
		mpr_fail_armed = 1'b1;
		send_cmd(8'h52);
		while (!o_mpr_error) step();
		while (!o_run_set) step();
		repeat (60) step();
		check_flag(o_mpr_error, 1'b1, "MPR error stays set");

		$display("All checks passed");
		$finish;
	end

endmodule
